// File: build.f
hw/tms_isa_pkg.sv
hw/tms_seq_pkg.sv
hw/tms_bus_ctrl.sv
hw/tms_alu.sv
hw/tms_datapath.sv
hw/tms_sequencer.sv
hw/tms_cpu_top.sv
test/tms_cpu_props.sv
test/tb_tms_cpu.sv

// File: test/tb_tms_cpu.sv
module tb_tms_cpu import tms_isa_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int    NUM_TESTS = 6;
   localparam word_t BOOT_PC   = 16'h0100;
   localparam word_t BOOT_WP   = 16'h0080;

   typedef word_t prog_t[$];

   logic     clk;
   logic     reset;
   logic     ready;
   word_t    d_in;
   logic     mem_en;
   logic     we;
   logic     iaq;
   logic     waiting;
   wd_addr_t a;
   word_t    q;
   word_t    debug_pc;
   status_t  debug_st;

   word_t    mem [0:32767];
   int       delay;
   wd_addr_t fetch_log[$];
   logic     first_seen;
   logic     first_iaq;
   logic     first_we;
   int       bus_cycles;
   int       wait_cycles;
   wd_addr_t end_word;
   logic     end_seen;
   string    test_name;

   tms_cpu_top #(
      .BOOT_PC (BOOT_PC),
      .BOOT_WP (BOOT_WP)
   ) uut (
      .clk      (clk),
      .reset    (reset),
      .mem_en   (mem_en),
      .we       (we),
      .iaq      (iaq),
      .waiting  (waiting),
      .a        (a),
      .d_in     (d_in),
      .q        (q),
      .ready    (ready),
      .debug_pc (debug_pc),
      .debug_st (debug_st)
   );

   bind tms_cpu_top tms_cpu_props u_props (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Memory with 0 to 3 extra wait cycles per access
   initial begin
      void'($urandom(32'h1ee5_251f));
      forever begin
         @(posedge clk);
         if (reset || ready) begin
            ready <= 1'b0;
            delay <= $urandom_range(3, 0);
         end else if (mem_en) begin
            if (delay == 0) begin
               ready <= 1'b1;
               if (we)
                  mem[a] <= q;
               else
                  d_in <= mem[a];
            end else begin
               delay <= delay - 1;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         if (waiting)
            wait_cycles++;
         if (mem_en && ready) begin
            bus_cycles++;
            if (!first_seen) begin
               first_seen = 1'b1;
               first_iaq  = iaq;
               first_we   = we;
            end
            if (iaq) begin
               fetch_log.push_back(a);
               if (a == end_word)
                  end_seen = 1'b1;
            end
         end
      end
   end

   always @(negedge clk) begin
      if (!reset)
         check_bit({test_name, " waiting"}, mem_en && !ready, waiting);
   end

   initial begin
      repeat (NUM_TESTS * 2000) @(posedge clk);
      fail_run("Timeout: the tests did not finish in the expected number of cycles");
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp)
         fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_st(input string name, input status_t exp, input status_t act);
      if (act !== exp)
         fail_run($sformatf("MISMATCH %s: expected st %h, actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input wd_addr_t exp, input wd_addr_t act);
      if (act !== exp)
         fail_run($sformatf("MISMATCH %s: expected address %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
   endtask

   function automatic word_t reg_value(input word_t wsp, input int r);
      return mem[wsp[0:14] + r];
   endfunction

   // Leaves the core in reset with the program loaded
   task automatic start_program(input prog_t prog);
      @(posedge clk);
      reset <= 1'b1;
      repeat (4) @(posedge clk);
      for (int i = 0; i < 32768; i++)
         mem[i] = {1'b1, i[14:0]} ^ 16'h3c5a;
      foreach (prog[k])
         mem[BOOT_PC[0:14] + k] = prog[k];
   endtask

   task automatic run_to_end(input string name, input word_t end_addr);
      int cycles;
      cycles      = 0;
      test_name   = name;
      end_word    = end_addr[0:14];
      end_seen    = 1'b0;
      first_seen  = 1'b0;
      bus_cycles  = 0;
      wait_cycles = 0;
      fetch_log.delete();
      @(posedge clk);
      reset <= 1'b0;
      while (!end_seen && cycles < 1900) begin
         @(posedge clk);
         cycles++;
      end
      if (!end_seen)
         fail_run($sformatf("%s: program never reached its end address", name));
      check_word({name, " pc"}, end_addr + 16'd2, debug_pc);   // Past the self-jump
   endtask

   task automatic test_reset_fetch;
      prog_t prog;
      prog = '{16'h0000, 16'h0000, 16'h0000, 16'h10ff};   // Illegal words, then self-jump
      start_program(prog);
      run_to_end("reset_fetch", 16'h0106);
      check_bit("reset_fetch first iaq", 1'b1, first_iaq);
      check_bit("reset_fetch first we", 1'b0, first_we);
      for (int i = 0; i < 4; i++)
         check_addr("reset_fetch", wd_addr_t'(BOOT_PC[0:14] + i), fetch_log[i]);
   endtask

   task automatic test_workspace;
      prog_t prog;
      prog = '{16'h02e0, 16'h0200, 16'h0203, 16'h1234, 16'h02a5, 16'h10ff};
      start_program(prog);
      run_to_end("workspace", 16'h010a);
      check_word("workspace R3", 16'h1234, reg_value(16'h0200, 3));
      check_word("workspace R5", 16'h0200, reg_value(16'h0200, 5));
      check_word("workspace old R3", {1'b1, 15'h0043} ^ 16'h3c5a, reg_value(BOOT_WP, 3));
      check_st("workspace", 16'hc000, debug_st);
   endtask

   task automatic test_immediate;
      prog_t prog;
      prog = '{16'h0201, 16'h7fff, 16'h0221, 16'h0001, 16'h02c8,
               16'h0202, 16'hffff, 16'h0222, 16'h0001, 16'h02c9,
               16'h0203, 16'hf0f0, 16'h0243, 16'h0ff0, 16'h02ca,
               16'h0263, 16'h8001, 16'h02cb, 16'h0283, 16'h80f1, 16'h10ff};
      start_program(prog);
      run_to_end("immediate", 16'h0128);
      check_word("immediate R1", 16'h8000, reg_value(BOOT_WP, 1));
      check_word("immediate st after AI overflow", 16'h8800, reg_value(BOOT_WP, 8));
      check_word("immediate R2", 16'h0000, reg_value(BOOT_WP, 2));
      check_word("immediate st after AI carry", 16'h3000, reg_value(BOOT_WP, 9));
      check_word("immediate st after ANDI", 16'hd000, reg_value(BOOT_WP, 10));
      check_word("immediate st after ORI", 16'h9000, reg_value(BOOT_WP, 11));
      check_word("immediate R3", 16'h80f1, reg_value(BOOT_WP, 3));
      check_st("immediate CI", 16'h3000, debug_st);
   endtask

   function automatic prog_t dual_program();
      return '{16'h0201, 16'h0005, 16'h0202, 16'h0003, 16'h6081, 16'h02c8,
               16'ha081, 16'h02c9, 16'hc0c1, 16'h0204, 16'hff00, 16'he101,
               16'h02ca, 16'h0205, 16'h00ff, 16'h4141, 16'h8144, 16'h10ff};
   endfunction

   task automatic check_dual(input string name);
      check_word({name, " R2"}, 16'h0003, reg_value(BOOT_WP, 2));
      check_word({name, " st after S"}, 16'h8000, reg_value(BOOT_WP, 8));
      check_word({name, " st after A"}, 16'hd000, reg_value(BOOT_WP, 9));
      check_word({name, " R3"}, 16'h0005, reg_value(BOOT_WP, 3));
      check_word({name, " R4"}, 16'hff05, reg_value(BOOT_WP, 4));
      check_word({name, " st after SOC"}, 16'h9000, reg_value(BOOT_WP, 10));
      check_word({name, " R5"}, 16'h00fa, reg_value(BOOT_WP, 5));
      check_st({name, " C"}, 16'h9000, debug_st);
   endtask

   task automatic test_dual;
      start_program(dual_program());
      run_to_end("dual", 16'h0122);
      check_dual("dual");
   endtask

   task automatic test_jumps;
      prog_t prog;
      word_t end_addr;
      word_t imms[12] = '{16'h0005, 16'h7fff, 16'h0003, 16'h0005, 16'hffff, 16'hffff,
                          16'h0005, 16'h0005, 16'h0005, 16'h0005, 16'h7fff, 16'h0003};
      bit    taken[12] = '{1, 1, 0, 1, 0, 1, 0, 0, 1, 0, 1, 1};
      // Sets C and OV, then R0 = 5
      prog = '{16'h0200, 16'h8000, 16'h0220, 16'h8000, 16'h0200, 16'h0005};
      for (int i = 0; i < 12; i++) begin
         prog.push_back(16'h0280);
         prog.push_back(imms[i]);
         prog.push_back(16'h1002 | (word_t'(i) << 8));   // Skips the marker LI
         prog.push_back(16'h0200 | word_t'(i + 1));
         prog.push_back(16'h0001);
      end
      prog.push_back(16'h10ff);
      end_addr = BOOT_PC + word_t'(2 * (prog.size() - 1));
      start_program(prog);
      for (int k = 1; k <= 12; k++)
         mem[BOOT_WP[0:14] + k] = 16'h0000;
      run_to_end("jumps", end_addr);
      for (int i = 0; i < 12; i++)
         check_word($sformatf("jumps cond %0d", i), taken[i] ? 16'h0000 : 16'h0001,
                    reg_value(BOOT_WP, i + 1));
      check_st("jumps", 16'hd800, debug_st);
   endtask

   task automatic test_bus_latency;
      start_program(dual_program());
      run_to_end("latency", 16'h0122);
      check_dual("latency");
      if (wait_cycles <= bus_cycles)
         fail_run("latency: memory never added extra wait cycles");
   endtask

   initial begin
      reset = 1'b1;
      ready = 1'b0;
      d_in  = '0;
      end_word = '1;
      end_seen = 1'b0;
      first_seen = 1'b0;
      bus_cycles = 0;
      wait_cycles = 0;
      test_reset_fetch();
      test_workspace();
      test_immediate();
      test_dual();
      test_jumps();
      test_bus_latency();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: test/tms_cpu_props.sv
module tms_cpu_props import tms_isa_pkg::*; (
   input logic     clk,
   input logic     reset,
   input logic     mem_en,
   input logic     we,
   input logic     iaq,
   input logic     waiting,
   input logic     ready,
   input wd_addr_t a,
   input word_t    q
);

   timeunit 1ns;
   timeprecision 1ps;

   mem_en_reset: assert property (@(posedge clk) reset |=> !mem_en)
      else $error("mem_en high during or right after reset");

   mem_en_after_reset: assert property (@(posedge clk) $fell(reset) |=> !mem_en)
      else $error("mem_en high on the cycle after reset");

   no_write_fetch: assert property (@(posedge clk) disable iff (reset) !(we && iaq))
      else $error("we and iaq high together");

   // Bus fields hold while the memory stalls
   stable_while_waiting: assert property (@(posedge clk) disable iff (reset)
      waiting |=> $stable(a) && $stable(we) && $stable(q))
      else $error("bus fields changed while waiting");

   mem_en_drop: assert property (@(posedge clk) disable iff (reset)
      mem_en && ready |=> !mem_en)
      else $error("mem_en did not fall after ready");

endmodule

// File: hw/tms_cpu_top.sv
module tms_cpu_top import tms_isa_pkg::*, tms_seq_pkg::*; #(
   parameter word_t BOOT_PC = 16'h0100,
   parameter word_t BOOT_WP = 16'h0080
) (
   input  logic     clk,
   input  logic     reset,
   output logic     mem_en,
   output logic     we,
   output logic     iaq,
   output logic     waiting,
   output wd_addr_t a,
   input  word_t    d_in,
   output word_t    q,
   input  logic     ready,
   output word_t    debug_pc,
   output status_t  debug_st
);

   logic       mem_start;
   logic       mem_write;
   logic       seq_iaq;
   logic       mem_done;
   word_t      rd_word;
   word_t      bus_addr;
   word_t      wdata;
   word_t      ir;
   word_t      operand;
   word_t      alu_result;
   status_t    alu_st;
   logic       ld_ir;
   logic       ld_operand;
   logic       ld_addr;
   logic       ld_result;
   logic       ld_st;
   logic       ld_wp;
   logic       pc_inc;
   logic       pc_jump;
   logic [1:0] addr_sel;
   alu_op_e    alu_op;

   tms_bus_ctrl u_bus (
      .clk       (clk),
      .reset     (reset),
      .mem_start (mem_start),
      .mem_write (mem_write),
      .addr      (bus_addr),
      .wdata     (wdata),
      .d_in      (d_in),
      .ready     (ready),
      .iaq_in    (seq_iaq),
      .mem_en    (mem_en),
      .we        (we),
      .iaq       (iaq),
      .a         (a),
      .q         (q),
      .waiting   (waiting),
      .mem_done  (mem_done),
      .rd_word   (rd_word)
   );

   tms_alu u_alu (
      .op     (alu_op),
      .src    (operand),
      .dst    (rd_word),
      .st_in  (debug_st),
      .result (alu_result),
      .st_out (alu_st)
   );

   tms_datapath #(
      .BOOT_PC (BOOT_PC),
      .BOOT_WP (BOOT_WP)
   ) u_datapath (
      .clk        (clk),
      .reset      (reset),
      .ld_ir      (ld_ir),
      .ld_operand (ld_operand),
      .ld_addr    (ld_addr),
      .ld_result  (ld_result),
      .ld_st      (ld_st),
      .ld_wp      (ld_wp),
      .pc_inc     (pc_inc),
      .addr_sel   (addr_sel),
      .pc_jump    (pc_jump),
      .rd_word    (rd_word),
      .alu_result (alu_result),
      .alu_st     (alu_st),
      .pc         (debug_pc),
      .wp         (),
      .operand    (operand),
      .st         (debug_st),
      .ir         (ir),
      .addr       (bus_addr),
      .wdata      (wdata)
   );

   tms_sequencer u_seq (
      .clk        (clk),
      .reset      (reset),
      .ir         (ir),
      .st         (debug_st),
      .mem_done   (mem_done),
      .mem_start  (mem_start),
      .mem_write  (mem_write),
      .iaq        (seq_iaq),
      .ld_ir      (ld_ir),
      .ld_operand (ld_operand),
      .ld_addr    (ld_addr),
      .ld_result  (ld_result),
      .ld_st      (ld_st),
      .ld_wp      (ld_wp),
      .pc_inc     (pc_inc),
      .addr_sel   (addr_sel),
      .pc_jump    (pc_jump),
      .alu_op     (alu_op)
   );

endmodule

// File: hw/tms_sequencer.sv
module tms_sequencer import tms_isa_pkg::*, tms_seq_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      ir,
   input  status_t    st,
   input  logic       mem_done,
   output logic       mem_start,
   output logic       mem_write,
   output logic       iaq,
   output logic       ld_ir,
   output logic       ld_operand,
   output logic       ld_addr,
   output logic       ld_result,
   output logic       ld_st,
   output logic       ld_wp,
   output logic       pc_inc,
   output logic [1:0] addr_sel,
   output logic       pc_jump,
   output alu_op_e    alu_op
);

   seq_state_e state;
   seq_state_e next_state;
   opcode_e    opcode;
   jcond_e     jcond;
   logic       take;
   logic       dual;
   logic       compare;
   logic       issue;
   logic       issue_write;
   logic       issue_iaq;

   always_comb begin
      opcode = OP_ILLEGAL;
      if (ir[0:2] != 3'b000) begin
         if (!ir[3] && ir[4:5] == 2'b00 && ir[10:11] == 2'b00) begin   // Word, register direct
            case (ir[0:2])
               3'b010:  opcode = OP_SZC;
               3'b011:  opcode = OP_S;
               3'b100:  opcode = OP_C;
               3'b101:  opcode = OP_A;
               3'b110:  opcode = OP_MOV;
               3'b111:  opcode = OP_SOC;
               default: opcode = OP_ILLEGAL;
            endcase
         end
      end else if (ir[3]) begin
         if (ir[4:7] <= 4'd11)
            opcode = OP_JUMP;
      end else if (ir[4:7] == 4'h2 && !ir[11]) begin
         case (ir[8:10])
            3'b000: opcode = OP_LI;
            3'b001: opcode = OP_AI;
            3'b010: opcode = OP_ANDI;
            3'b011: opcode = OP_ORI;
            3'b100: opcode = OP_CI;
            3'b101: opcode = OP_STWP;
            3'b110: opcode = OP_STST;
            3'b111: opcode = OP_LWPI;
         endcase
      end
   end

   assign dual    = opcode inside {OP_A, OP_S, OP_C, OP_MOV, OP_SOC, OP_SZC};
   assign compare = opcode inside {OP_CI, OP_C};

   always_comb begin
      jcond = jcond_e'(ir[4:7]);
      case (jcond)
         JMP:     take = 1'b1;
         JLT:     take = !st[ST_AGT] && !st[ST_EQ];
         JLE:     take = !st[ST_LGT] || st[ST_EQ];
         JEQ:     take = st[ST_EQ];
         JHE:     take = st[ST_LGT] || st[ST_EQ];
         JGT:     take = st[ST_AGT];
         JNE:     take = !st[ST_EQ];
         JNC:     take = !st[ST_C];
         JOC:     take = st[ST_C];
         JNO:     take = !st[ST_OV];
         JL:      take = !st[ST_LGT] && !st[ST_EQ];
         JH:      take = st[ST_LGT] && !st[ST_EQ];
         default: take = 1'b0;
      endcase
   end

   always_comb begin
      case (opcode)
         OP_AI, OP_A:            alu_op = ALU_ADD;
         OP_S:                   alu_op = ALU_SUB;
         OP_ANDI:                alu_op = ALU_AND;
         OP_ORI, OP_SOC:         alu_op = ALU_OR;
         OP_SZC:                 alu_op = ALU_ANDN;
         OP_CI, OP_C:            alu_op = ALU_CMP;
         default:                alu_op = ALU_PASS;
      endcase
   end

   always_comb begin
      next_state  = state;
      issue       = 1'b0;
      issue_write = 1'b0;
      issue_iaq   = 1'b0;
      ld_ir       = 1'b0;
      ld_operand  = 1'b0;
      ld_addr     = 1'b0;
      ld_result   = 1'b0;
      ld_st       = 1'b0;
      ld_wp       = 1'b0;
      pc_inc      = 1'b0;
      pc_jump     = 1'b0;
      addr_sel    = ASEL_PC;
      case (state)
         S_RESET: next_state = S_FETCH;
         S_FETCH: begin
            ld_addr    = 1'b1;
            pc_inc     = 1'b1;
            issue      = 1'b1;
            issue_iaq  = 1'b1;
            next_state = S_FETCH_WAIT;
         end
         S_FETCH_WAIT: begin
            ld_ir = mem_done;
            if (mem_done)
               next_state = S_DECODE;
         end
         S_DECODE: begin
            case (opcode)
               OP_LI, OP_LWPI: next_state = S_IMM_FETCH;
               OP_STWP, OP_STST: begin
                  ld_operand = 1'b1;   // Captures wp or st
                  next_state = S_EXECUTE;
               end
               OP_JUMP:    next_state = S_JUMP;
               OP_ILLEGAL: next_state = S_FETCH;
               default:    next_state = S_SRC_READ;
            endcase
         end
         S_IMM_FETCH: begin
            ld_addr    = 1'b1;
            pc_inc     = 1'b1;
            issue      = 1'b1;
            next_state = S_IMM_WAIT;
         end
         S_IMM_WAIT: begin
            if (mem_done) begin
               ld_wp      = opcode == OP_LWPI;
               ld_operand = opcode == OP_LI;
               next_state = (opcode == OP_LWPI) ? S_FETCH : S_EXECUTE;
            end
         end
         S_SRC_READ: begin
            addr_sel   = ASEL_TS;
            ld_addr    = 1'b1;
            issue      = 1'b1;
            next_state = S_SRC_WAIT;
         end
         S_SRC_WAIT: begin
            ld_operand = mem_done;
            if (mem_done)
               next_state = dual ? S_REG_READ : S_IMM_FETCH;   // Immediate comes second
         end
         S_REG_READ: begin
            addr_sel   = ASEL_TD;
            ld_addr    = 1'b1;
            issue      = 1'b1;
            next_state = S_REG_WAIT;
         end
         S_REG_WAIT: begin
            if (mem_done)
               next_state = S_EXECUTE;
         end
         S_EXECUTE: begin
            ld_result  = 1'b1;
            ld_st      = !(opcode inside {OP_STWP, OP_STST});
            next_state = compare ? S_FETCH : S_WRITEBACK;
         end
         S_WRITEBACK: begin
            addr_sel    = dual ? ASEL_TD : ASEL_TS;
            ld_addr     = 1'b1;
            issue       = 1'b1;
            issue_write = 1'b1;
            next_state  = S_WB_WAIT;
         end
         S_WB_WAIT: begin
            if (mem_done)
               next_state = S_FETCH;
         end
         S_JUMP: begin
            pc_jump    = take;
            next_state = S_FETCH;
         end
         default: next_state = S_RESET;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= S_RESET;
         mem_start <= 1'b0;
         mem_write <= 1'b0;
         iaq       <= 1'b0;
      end else begin
         state     <= next_state;
         mem_start <= issue;   // One cycle after the address load
         mem_write <= issue_write;
         iaq       <= issue_iaq;
      end
   end

endmodule

// File: hw/tms_datapath.sv
module tms_datapath import tms_isa_pkg::*, tms_seq_pkg::*; #(
   parameter word_t BOOT_PC = 16'h0100,
   parameter word_t BOOT_WP = 16'h0080
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       ld_ir,
   input  logic       ld_operand,
   input  logic       ld_addr,
   input  logic       ld_result,
   input  logic       ld_st,
   input  logic       ld_wp,
   input  logic       pc_inc,
   input  logic [1:0] addr_sel,
   input  logic       pc_jump,
   input  word_t      rd_word,
   input  word_t      alu_result,
   input  status_t    alu_st,
   output word_t      pc,
   output word_t      wp,
   output word_t      operand,
   output status_t    st,
   output word_t      ir,
   output word_t      addr,
   output word_t      wdata
);

   reg_idx_t ts_field;
   reg_idx_t td_field;
   word_t    ws_ts;
   word_t    ws_td;
   word_t    jump_offset;
   word_t    addr_next;
   word_t    result;
   logic     store_reg;

   assign ts_field    = ir[12:15];
   assign td_field    = ir[6:9];
   assign ws_ts       = wp + {11'b0, ts_field, 1'b0};
   assign ws_td       = wp + {11'b0, td_field, 1'b0};
   assign jump_offset = {{7{ir[8]}}, ir[8:15], 1'b0};   // Displacement in bytes
   assign store_reg   = (ir[0:7] == 8'h02) && ir[8] && (ir[9] != ir[10]);   // STWP or STST
   assign wdata       = result;

   always_comb begin
      case (addr_sel)
         ASEL_TS:      addr_next = ws_ts;
         ASEL_TD:      addr_next = ws_td;
         ASEL_OPERAND: addr_next = operand;
         default:      addr_next = pc;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= BOOT_PC;
         wp <= BOOT_WP;
         st <= '0;
         ir <= '0;
      end else begin
         if (pc_jump)
            pc <= pc + jump_offset;
         else if (pc_inc)
            pc <= pc + 16'd2;
         if (ld_wp)
            wp <= rd_word;
         if (ld_st)
            st <= alu_st;
         if (ld_ir)
            ir <= rd_word;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_addr)
         addr <= addr_next;
      if (ld_operand)
         operand <= store_reg ? (ir[10] ? wp : st) : rd_word;
      if (ld_result)
         result <= alu_result;
   end

endmodule

// File: hw/tms_alu.sv
module tms_alu import tms_isa_pkg::*, tms_seq_pkg::*; (
   input  alu_op_e op,
   input  word_t   src,
   input  word_t   dst,
   input  status_t st_in,
   output word_t   result,
   output status_t st_out
);

   word_t       addend;
   logic [0:16] sum;      // Bit 0 is the carry out

   // SUB and CMP add the inverted source plus one
   always_comb begin
      addend = (op == ALU_ADD) ? src : ~src;
      sum    = {1'b0, dst} + {1'b0, addend} + ((op == ALU_ADD) ? 17'd0 : 17'd1);
   end

   always_comb begin
      case (op)
         ALU_ADD, ALU_SUB, ALU_CMP: result = sum[1:16];
         ALU_AND:                   result = dst & src;
         ALU_OR:                    result = dst | src;
         ALU_ANDN:                  result = dst & ~src;
         default:                   result = src;
      endcase
   end

   always_comb begin
      st_out        = '0;
      st_out[ST_C]  = st_in[ST_C];
      st_out[ST_OV] = st_in[ST_OV];
      if (op == ALU_CMP) begin
         // src is the first operand
         st_out[ST_LGT] = src > dst;
         st_out[ST_AGT] = $signed(src) > $signed(dst);
         st_out[ST_EQ]  = src == dst;
      end else begin
         st_out[ST_LGT] = |result;
         st_out[ST_AGT] = |result && !result[0];
         st_out[ST_EQ]  = ~|result;
      end
      if (op == ALU_ADD || op == ALU_SUB) begin
         st_out[ST_C]  = sum[0];
         st_out[ST_OV] = (dst[0] == addend[0]) && (result[0] != dst[0]);
      end
   end

endmodule

// File: hw/tms_bus_ctrl.sv
module tms_bus_ctrl import tms_isa_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     mem_start,
   input  logic     mem_write,
   input  word_t    addr,
   input  word_t    wdata,
   input  word_t    d_in,
   input  logic     ready,
   input  logic     iaq_in,
   output logic     mem_en,
   output logic     we,
   output logic     iaq,
   output wd_addr_t a,
   output word_t    q,
   output logic     waiting,
   output logic     mem_done,
   output word_t    rd_word
);

   logic cycle_end;

   assign cycle_end = mem_en && ready;
   assign waiting   = mem_en && !ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_en   <= 1'b0;
         we       <= 1'b0;
         iaq      <= 1'b0;
         mem_done <= 1'b0;
      end else begin
         mem_done <= cycle_end;
         if (mem_start) begin
            mem_en <= 1'b1;
            we     <= mem_write;
            iaq    <= iaq_in;
         end else if (cycle_end) begin
            mem_en <= 1'b0;   // Drops on the edge that saw ready
            we     <= 1'b0;
            iaq    <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_start) begin
         a <= addr[0:14];
         q <= wdata;
      end
      if (cycle_end && !we)
         rd_word <= d_in;
   end

endmodule

// File: hw/tms_seq_pkg.sv
package tms_seq_pkg;

   typedef enum logic [4:0] {
      S_RESET,
      S_FETCH,
      S_FETCH_WAIT,
      S_DECODE,
      S_IMM_FETCH,
      S_IMM_WAIT,
      S_REG_READ,
      S_REG_WAIT,
      S_SRC_READ,
      S_SRC_WAIT,
      S_EXECUTE,
      S_WRITEBACK,
      S_WB_WAIT,
      S_JUMP
   } seq_state_e;

   typedef enum logic [2:0] {
      ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_ANDN, ALU_CMP
   } alu_op_e;

   // Address register source
   localparam logic [1:0] ASEL_PC      = 2'd0;
   localparam logic [1:0] ASEL_TS      = 2'd1;
   localparam logic [1:0] ASEL_TD      = 2'd2;
   localparam logic [1:0] ASEL_OPERAND = 2'd3;

endpackage

// File: hw/tms_isa_pkg.sv
package tms_isa_pkg;

   typedef logic [0:15] word_t;      // Bit 0 is the MSB
   typedef logic [0:14] wd_addr_t;   // Word address, byte bit dropped
   typedef logic [0:3]  reg_idx_t;
   typedef logic [0:15] status_t;

   // Flag positions in st
   localparam int ST_LGT = 0;
   localparam int ST_AGT = 1;
   localparam int ST_EQ  = 2;
   localparam int ST_C   = 3;
   localparam int ST_OV  = 4;

   typedef enum logic [3:0] {
      OP_LI,
      OP_AI,
      OP_ANDI,
      OP_ORI,
      OP_CI,
      OP_LWPI,
      OP_STWP,
      OP_STST,
      OP_JUMP,
      OP_A,
      OP_S,
      OP_C,
      OP_MOV,
      OP_SOC,
      OP_SZC,
      OP_ILLEGAL
   } opcode_e;

   // Encoded as ir[4:7] of the jump group
   typedef enum logic [3:0] {
      JMP, JLT, JLE, JEQ, JHE, JGT,
      JNE, JNC, JOC, JNO, JL, JH
   } jcond_e;

endpackage
